// ==== logic/rare_params.svh ====
`ifndef RARE_PARAMS_SVH
`define RARE_PARAMS_SVH

// ------------------------------------------------------------
// memory geometry
// ------------------------------------------------------------
`define RARE_WORD_W     32
`define RARE_BE_W       4
`define RARE_MEM_AW     11
`define RARE_MEM_DEPTH  2048

// core byte address
`define RARE_CORE_AW    32

// mailbox word in the data bank
`define RARE_STOP_ADDR  11'h7FF

// ------------------------------------------------------------
// trace field widths
// ------------------------------------------------------------
`define RARE_PC_W       11
`define RARE_REG_AW     6
`define RARE_ALU_OP_W   7
`define RARE_MULT_OP_W  3

`endif

// ==== logic/rare_mem_pkg.sv ====
`include "rare_params.svh"

package rare_mem_pkg;

    // host access as seen on the stream port
    typedef struct packed {
        logic                    en;
        logic                    we;
        logic [`RARE_MEM_AW-1:0] addr;
        logic [`RARE_WORD_W-1:0] wdata;
    } stream_req_t;

    // request at the ram pins after the owner mux
    // wmask is active high, one bit per data bit
    typedef struct packed {
        logic                    en;
        logic                    we;
        logic [`RARE_MEM_AW-1:0] addr;
        logic [`RARE_WORD_W-1:0] wdata;
        logic [`RARE_WORD_W-1:0] wmask;
    } mem_req_t;

    // core fetch port
    typedef struct packed {
        logic                     req;
        logic [`RARE_CORE_AW-1:0] addr;
    } core_rd_req_t;

    // core load/store port
    typedef struct packed {
        logic                     req;
        logic                     we;
        logic [`RARE_CORE_AW-1:0] addr;
        logic [`RARE_BE_W-1:0]    be;
        logic [`RARE_WORD_W-1:0]  wdata;
    } core_rw_req_t;

endpackage

// ==== logic/rare_trace_pkg.sv ====
`include "rare_params.svh"

package rare_trace_pkg;

    // fetch stage observation
    typedef struct packed {
        logic                    instr_req;
        logic [`RARE_PC_W-1:0]   instr_addr;
        logic [`RARE_WORD_W-1:0] instr_rdata;
        logic                    fetch_failed;
        logic [`RARE_PC_W-1:0]   pc_if;
        logic [`RARE_PC_W-1:0]   pc_id;
    } if_trace_t;

    // decode stage observation
    typedef struct packed {
        logic                       branch_in_ex;
        logic [`RARE_PC_W-1:0]      jump_target_id;
        logic                       alu_en;
        logic [`RARE_ALU_OP_W-1:0]  alu_operator;
        logic                       mult_en;
        logic [`RARE_MULT_OP_W-1:0] mult_operator;
    } id_trace_t;

    // execute stage observation
    // wb_* is the writeback port, alu_* the alu forward port
    typedef struct packed {
        logic [`RARE_PC_W-1:0]   jump_target_ex;
        logic                    branch_decision;
        logic [`RARE_REG_AW-1:0] wb_waddr;
        logic                    wb_we;
        logic [`RARE_WORD_W-1:0] wb_wdata;
        logic [`RARE_REG_AW-1:0] alu_waddr;
        logic                    alu_we;
        logic [`RARE_WORD_W-1:0] alu_wdata;
    } ex_trace_t;

endpackage

// ==== logic/sram_model.sv ====
`timescale 1ns/10ps

`include "rare_params.svh"

module sram_model (
    input  logic                    core_clk,
    input  rare_mem_pkg::mem_req_t  mem_req_i,
    output logic [`RARE_WORD_W-1:0] rdata_o
);

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------
    logic [`RARE_WORD_W-1:0] mem_array [0:`RARE_MEM_DEPTH-1];

    // current content of the addressed word
    logic [`RARE_WORD_W-1:0] cur_word;

    // merged word for a masked write
    logic [`RARE_WORD_W-1:0] merged_word;

    assign cur_word = mem_array[mem_req_i.addr];

    // masked bits from wdata, the rest kept
    assign merged_word = (cur_word & ~mem_req_i.wmask) |
                         (mem_req_i.wdata & mem_req_i.wmask);

    // ------------------------------------------------------------
    // single port access
    // ------------------------------------------------------------
    // write cycles leave rdata_o untouched
    always_ff @(posedge core_clk) begin
        if (mem_req_i.en) begin
            if (mem_req_i.we) begin
                mem_array[mem_req_i.addr] <= merged_word;
            end else begin
                rdata_o <= cur_word;
            end
        end
    end

endmodule

// ==== logic/mem_bank.sv ====
`timescale 1ns/10ps

`include "rare_params.svh"

module mem_bank #(
    parameter type core_req_type = rare_mem_pkg::core_rd_req_t,
    parameter int  CORE_WRITES   = 0
) (
    input  logic                      core_clk,
    input  logic                      core_resetb,
    input  logic                      fetch_enable_i,
    input  rare_mem_pkg::stream_req_t stream_req_i,
    input  core_req_type              core_req_i,
    output logic [`RARE_WORD_W-1:0]   stream_rdata_o,
    output logic [`RARE_WORD_W-1:0]   core_rdata_o,
    output logic                      core_rvalid_o,
    output rare_mem_pkg::mem_req_t    mem_req_o
);

    localparam int BYTE_W = `RARE_WORD_W / `RARE_BE_W;

    rare_mem_pkg::stream_req_t stream_req_q;
    rare_mem_pkg::mem_req_t    stream_mem_req;
    rare_mem_pkg::mem_req_t    core_mem_req;
    logic [`RARE_WORD_W-1:0]   ram_rdata;

    // ------------------------------------------------------------
    // stream input stage
    // ------------------------------------------------------------
    // one register between host pins and ram for timing
    always_ff @(posedge core_clk or negedge core_resetb) begin
        if (!core_resetb) begin
            stream_req_q <= '0;
        end else begin
            stream_req_q <= stream_req_i;
        end
    end

    // host writes always cover the full word
    always_comb begin
        stream_mem_req       = '0;
        stream_mem_req.en    = stream_req_q.en;
        stream_mem_req.we    = stream_req_q.we;
        stream_mem_req.addr  = stream_req_q.addr;
        stream_mem_req.wdata = stream_req_q.wdata;
        stream_mem_req.wmask = '1;
    end

    // ------------------------------------------------------------
    // core request shaping
    // ------------------------------------------------------------
    // word index from byte address bits 12:2
    generate
        if (CORE_WRITES != 0) begin : g_core_rw
            // byte enable k covers bits 8k+7 down to 8k
            always_comb begin
                core_mem_req       = '0;
                core_mem_req.en    = core_req_i.req;
                core_mem_req.we    = core_req_i.we;
                core_mem_req.addr  = core_req_i.addr[`RARE_MEM_AW+1:2];
                core_mem_req.wdata = core_req_i.wdata;
                for (int k = 0; k < `RARE_BE_W; k++) begin
                    core_mem_req.wmask[k*BYTE_W +: BYTE_W] = {BYTE_W{core_req_i.be[k]}};
                end
            end
        end else begin : g_core_ro
            // fetch only, never writes
            always_comb begin
                core_mem_req      = '0;
                core_mem_req.en   = core_req_i.req;
                core_mem_req.addr = core_req_i.addr[`RARE_MEM_AW+1:2];
            end
        end
    endgenerate

    // ------------------------------------------------------------
    // owner mux and ram
    // ------------------------------------------------------------
    // fetch_enable_i high hands the ram to the core
    assign mem_req_o = fetch_enable_i ? core_mem_req : stream_mem_req;

    sram_model sram_inst (
        .core_clk  (core_clk),
        .mem_req_i (mem_req_o),
        .rdata_o   (ram_rdata)
    );

    // both ports read the same ram output
    assign stream_rdata_o = ram_rdata;
    assign core_rdata_o   = ram_rdata;

    // one rvalid per accepted req, writes included
    always_ff @(posedge core_clk or negedge core_resetb) begin
        if (!core_resetb) begin
            core_rvalid_o <= 1'b0;
        end else begin
            core_rvalid_o <= core_req_i.req & fetch_enable_i;
        end
    end

endmodule

// ==== logic/stop_ctrl.sv ====
`timescale 1ns/10ps

`include "rare_params.svh"

module stop_ctrl (
    input  logic                   core_clk,
    input  logic                   core_resetb,
    input  rare_mem_pkg::mem_req_t mem_req_i,
    output logic                   riscv_ready_o,
    output logic                   riscv_debug_o
);

    logic       mbox_hit;
    logic       mbox_hit_q;
    logic [1:0] mbox_bits_q;

    // ------------------------------------------------------------
    // mailbox decode
    // ------------------------------------------------------------
    // any owner may write the mailbox
    assign mbox_hit = mem_req_i.en && mem_req_i.we &&
                      (mem_req_i.addr == `RARE_STOP_ADDR);

    // hit sampled on the ram write edge
    always_ff @(posedge core_clk or negedge core_resetb) begin
        if (!core_resetb) begin
            mbox_hit_q <= 1'b0;
        end else begin
            mbox_hit_q <= mbox_hit;
        end
    end

    // bit 1 debug and bit 0 ready
    always_ff @(posedge core_clk) begin
        if (mbox_hit) begin
            mbox_bits_q <= mem_req_i.wdata[1:0];
        end
    end

    // ------------------------------------------------------------
    // flag hold
    // ------------------------------------------------------------
    // flags change one edge after the mailbox write
    always_ff @(posedge core_clk or negedge core_resetb) begin
        if (!core_resetb) begin
            riscv_ready_o <= 1'b0;
            riscv_debug_o <= 1'b0;
        end else if (mbox_hit_q) begin
            riscv_ready_o <= mbox_bits_q[0];
            riscv_debug_o <= mbox_bits_q[1];
        end
    end

endmodule

// ==== logic/trace_capture.sv ====
`timescale 1ns/10ps

module trace_capture (
    input  logic                     core_clk,
    input  logic                     core_resetb,
    input  rare_trace_pkg::if_trace_t if_trace_i,
    input  rare_trace_pkg::id_trace_t id_trace_i,
    input  rare_trace_pkg::ex_trace_t ex_trace_i,
    output rare_trace_pkg::if_trace_t if_trace_o,
    output rare_trace_pkg::id_trace_t id_trace_o,
    output rare_trace_pkg::ex_trace_t ex_trace_o
);

    // ------------------------------------------------------------
    // fetch group
    // ------------------------------------------------------------
    always_ff @(posedge core_clk or negedge core_resetb) begin
        if (!core_resetb) begin
            if_trace_o <= '0;
        end else begin
            if_trace_o <= if_trace_i;
        end
    end

    // ------------------------------------------------------------
    // decode group
    // ------------------------------------------------------------
    always_ff @(posedge core_clk or negedge core_resetb) begin
        if (!core_resetb) begin
            id_trace_o <= '0;
        end else begin
            id_trace_o <= id_trace_i;
        end
    end

    // ------------------------------------------------------------
    // execute group
    // ------------------------------------------------------------
    // outside capture sees stable flops, not core nets
    always_ff @(posedge core_clk or negedge core_resetb) begin
        if (!core_resetb) begin
            ex_trace_o <= '0;
        end else begin
            ex_trace_o <= ex_trace_i;
        end
    end

endmodule

// ==== logic/rare_mem_top.sv ====
`timescale 1ns/10ps

`include "rare_params.svh"

module rare_mem_top (
    // clock, reset, ownership
    input  logic                        core_clk,
    input  logic                        core_resetb,
    input  logic                        fetch_enable_i,

    // host stream ports
    input  rare_mem_pkg::stream_req_t   instr_stream_i,
    input  rare_mem_pkg::stream_req_t   data_stream_i,
    output logic [`RARE_WORD_W-1:0]     instr_stream_rdata_o,
    output logic [`RARE_WORD_W-1:0]     data_stream_rdata_o,

    // core fetch port
    input  rare_mem_pkg::core_rd_req_t  instr_req_i,
    output logic [`RARE_WORD_W-1:0]     instr_rdata_o,
    output logic                        instr_rvalid_o,

    // core load/store port
    input  rare_mem_pkg::core_rw_req_t  data_req_i,
    output logic [`RARE_WORD_W-1:0]     data_rdata_o,
    output logic                        data_rvalid_o,

    // trace
    input  rare_trace_pkg::if_trace_t   if_trace_i,
    input  rare_trace_pkg::id_trace_t   id_trace_i,
    input  rare_trace_pkg::ex_trace_t   ex_trace_i,
    output rare_trace_pkg::if_trace_t   if_trace_o,
    output rare_trace_pkg::id_trace_t   id_trace_o,
    output rare_trace_pkg::ex_trace_t   ex_trace_o,

    // mailbox flags
    output logic                        riscv_ready_o,
    output logic                        riscv_debug_o
);

    // data bank ram request for the mailbox watcher
    rare_mem_pkg::mem_req_t data_mem_req;

    // ------------------------------------------------------------
    // instruction bank
    // ------------------------------------------------------------
    // read only toward the core
    mem_bank #(
        .core_req_type (rare_mem_pkg::core_rd_req_t),
        .CORE_WRITES   (0)
    ) instr_bank_inst (
        .core_clk       (core_clk),
        .core_resetb    (core_resetb),
        .fetch_enable_i (fetch_enable_i),
        .stream_req_i   (instr_stream_i),
        .core_req_i     (instr_req_i),
        .stream_rdata_o (instr_stream_rdata_o),
        .core_rdata_o   (instr_rdata_o),
        .core_rvalid_o  (instr_rvalid_o),
        .mem_req_o      ()
    );

    // ------------------------------------------------------------
    // data bank
    // ------------------------------------------------------------
    mem_bank #(
        .core_req_type (rare_mem_pkg::core_rw_req_t),
        .CORE_WRITES   (1)
    ) data_bank_inst (
        .core_clk       (core_clk),
        .core_resetb    (core_resetb),
        .fetch_enable_i (fetch_enable_i),
        .stream_req_i   (data_stream_i),
        .core_req_i     (data_req_i),
        .stream_rdata_o (data_stream_rdata_o),
        .core_rdata_o   (data_rdata_o),
        .core_rvalid_o  (data_rvalid_o),
        .mem_req_o      (data_mem_req)
    );

    // ------------------------------------------------------------
    // stop controller and trace
    // ------------------------------------------------------------
    stop_ctrl stop_ctrl_inst (
        .core_clk      (core_clk),
        .core_resetb   (core_resetb),
        .mem_req_i     (data_mem_req),
        .riscv_ready_o (riscv_ready_o),
        .riscv_debug_o (riscv_debug_o)
    );

    trace_capture trace_capture_inst (
        .core_clk    (core_clk),
        .core_resetb (core_resetb),
        .if_trace_i  (if_trace_i),
        .id_trace_i  (id_trace_i),
        .ex_trace_i  (ex_trace_i),
        .if_trace_o  (if_trace_o),
        .id_trace_o  (id_trace_o),
        .ex_trace_o  (ex_trace_o)
    );

endmodule

// ==== verif/rare_mem_tb.sv ====
`timescale 1ns/10ps

`include "rare_params.svh"

module rare_mem_tb;

    // one cycle of all three trace groups
    typedef struct packed {
        rare_trace_pkg::if_trace_t if_tr;
        rare_trace_pkg::id_trace_t id_tr;
        rare_trace_pkg::ex_trace_t ex_tr;
    } trace_set_t;

    logic                       core_clk;
    logic                       core_resetb;
    logic                       fetch_enable;
    rare_mem_pkg::stream_req_t  instr_stream;
    rare_mem_pkg::stream_req_t  data_stream;
    rare_mem_pkg::core_rd_req_t instr_req;
    rare_mem_pkg::core_rw_req_t data_req;
    logic [`RARE_WORD_W-1:0]    instr_stream_rdata, data_stream_rdata, instr_rdata, data_rdata;
    logic                       instr_rvalid, data_rvalid, riscv_ready, riscv_debug;
    rare_trace_pkg::if_trace_t  if_in, if_out;
    rare_trace_pkg::id_trace_t  id_in, id_out;
    rare_trace_pkg::ex_trace_t  ex_in, ex_out;

    // reference model
    logic [`RARE_WORD_W-1:0] instr_model [0:`RARE_MEM_DEPTH-1];
    logic [`RARE_WORD_W-1:0] data_model [0:`RARE_MEM_DEPTH-1];
    logic [`RARE_MEM_AW-1:0] instr_addrs [$];
    logic [`RARE_MEM_AW-1:0] data_addrs [$];
    logic                    model_ready = 1'b0;
    logic                    model_debug = 1'b0;
    trace_set_t              trace_q [$];

    integer seed = 72;
    int     err_count = 0;
    int     test_count = 0;

    rare_mem_top rare_mem_top_inst (
        .core_clk (core_clk), .core_resetb (core_resetb), .fetch_enable_i (fetch_enable),
        .instr_stream_i (instr_stream), .data_stream_i (data_stream),
        .instr_stream_rdata_o (instr_stream_rdata), .data_stream_rdata_o (data_stream_rdata),
        .instr_req_i (instr_req), .instr_rdata_o (instr_rdata), .instr_rvalid_o (instr_rvalid),
        .data_req_i (data_req), .data_rdata_o (data_rdata), .data_rvalid_o (data_rvalid),
        .if_trace_i (if_in), .id_trace_i (id_in), .ex_trace_i (ex_in),
        .if_trace_o (if_out), .id_trace_o (id_out), .ex_trace_o (ex_out),
        .riscv_ready_o (riscv_ready), .riscv_debug_o (riscv_debug)
    );

    initial core_clk = 1'b0;
    always #10 core_clk = ~core_clk;

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    // random bits above and below the word index
    function automatic logic [31:0] to_byte_addr(input logic [`RARE_MEM_AW-1:0] word);
        logic [31:0] r;
        r = next_rand();
        to_byte_addr = {r[31:13], word, r[1:0]};
    endfunction

    function automatic logic [`RARE_MEM_AW-1:0] pick_addr(input bit from_data);
        if (from_data) pick_addr = data_addrs[next_rand() % data_addrs.size()];
        else pick_addr = instr_addrs[next_rand() % instr_addrs.size()];
    endfunction

    function automatic trace_set_t rand_trace();
        logic [191:0] r;
        r = {next_rand(), next_rand(), next_rand(), next_rand(), next_rand(), next_rand()};
        rand_trace = r[$bits(trace_set_t)-1:0];
    endfunction

    task automatic report_mismatch(input string sig, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("error %s expected %0h actual %0h", sig, exp, act);
        err_count++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) $display("test %0d %s passed", test_count, name);
        else $display("test %0d %s failed, %0d errors", test_count, name,
                      err_count - errs_before);
    endtask

    task automatic set_owner(input logic core_owns);
        @(posedge core_clk);
        fetch_enable <= core_owns;
    endtask

    task automatic check_flags(input logic exp_ready, input logic exp_debug);
        if (riscv_ready !== exp_ready) report_mismatch("riscv_ready_o", exp_ready, riscv_ready);
        if (riscv_debug !== exp_debug) report_mismatch("riscv_debug_o", exp_debug, riscv_debug);
    endtask

    // strobe, input register edge, ram edge
    task automatic stream_access(input bit to_data, input logic we,
                                 input logic [`RARE_MEM_AW-1:0] addr, input logic [31:0] wdata);
        @(posedge core_clk);
        if (to_data) data_stream <= {1'b1, we, addr, wdata};
        else instr_stream <= {1'b1, we, addr, wdata};
        @(posedge core_clk);
        data_stream <= '0;
        instr_stream <= '0;
        @(posedge core_clk);
        @(negedge core_clk);
        if (!we && to_data && data_stream_rdata !== data_model[addr])
            report_mismatch("data_stream_rdata_o", data_model[addr], data_stream_rdata);
        if (!we && !to_data && instr_stream_rdata !== instr_model[addr])
            report_mismatch("instr_stream_rdata_o", instr_model[addr], instr_stream_rdata);
        // host writes land only while the host owns the bank
        if (we && !fetch_enable && to_data) begin
            data_model[addr] = wdata;
            if (addr == `RARE_STOP_ADDR) {model_debug, model_ready} = wdata[1:0];
        end
        if (we && !fetch_enable && !to_data) instr_model[addr] = wdata;
    endtask

    task automatic readback_all();
        foreach (instr_addrs[i]) stream_access(1'b0, 1'b0, instr_addrs[i], '0);
        foreach (data_addrs[i]) stream_access(1'b1, 1'b0, data_addrs[i], '0);
    endtask

    // returns on the negedge after the ram edge
    task automatic core_data_access(input logic we, input logic [31:0] byte_addr,
                                    input logic [3:0] be, input logic [31:0] wdata);
        int                      waits;
        logic [`RARE_MEM_AW-1:0] w;
        w = byte_addr[12:2];
        @(posedge core_clk);
        data_req <= {1'b1, we, byte_addr, be, wdata};
        @(posedge core_clk);
        data_req <= '0;
        waits = 0;
        @(negedge core_clk);
        while (!data_rvalid && waits < 10) begin
            @(negedge core_clk);
            waits++;
        end
        if (!data_rvalid) begin
            $display("timeout, data_rvalid_o never rose after a core access");
            err_count++;
        end else if (waits != 0) begin
            $display("data_rvalid_o rose %0d cycles late", waits);
            err_count++;
        end
        for (int k = 0; k < 4; k++)
            if (we && be[k]) data_model[w][8*k +: 8] = wdata[8*k +: 8];
        if (we && w == `RARE_STOP_ADDR) {model_debug, model_ready} = wdata[1:0];
        if (!we && data_rdata !== data_model[w])
            report_mismatch("data_rdata_o", data_model[w], data_rdata);
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        int                      errs;
        logic [`RARE_MEM_AW-1:0] a, last_word;
        logic                    last_req, cur_req;
        logic [31:0]             wd;
        logic [1:0]              old_flags;
        trace_set_t              new_tr, exp_tr;
        core_resetb = 1'b0;
        fetch_enable = 1'b0;
        instr_stream = '0;
        data_stream = '0;
        instr_req = '0;
        data_req = '0;
        {if_in, id_in, ex_in} = '0;
        repeat (5) @(posedge core_clk);
        core_resetb <= 1'b1;

        // host fills both banks
        errs = err_count;
        for (int i = 0; i < 16; i++) begin
            a = next_rand() % `RARE_MEM_DEPTH;
            instr_addrs.push_back(a);
            stream_access(1'b0, 1'b1, a, next_rand());
            a = next_rand() % `RARE_MEM_DEPTH;
            data_addrs.push_back(a);
            stream_access(1'b1, 1'b1, a, next_rand());
        end
        readback_all();
        finish_test("stream load and readback", errs);

        // wrong owner on either port
        errs = err_count;
        set_owner(1'b1);
        for (int i = 0; i < 8; i++) begin
            stream_access(1'b0, 1'b1, pick_addr(1'b0), next_rand());
            stream_access(1'b1, 1'b1, pick_addr(1'b1), next_rand());
        end
        set_owner(1'b0);
        for (int i = 0; i < 9; i++) begin
            @(posedge core_clk);
            wd = next_rand();
            instr_req <= (i < 8) ? {1'b1, to_byte_addr(pick_addr(1'b0))} : '0;
            data_req <= (i < 8) ? {1'b1, wd[0], to_byte_addr(pick_addr(1'b1)), wd[7:4],
                                   next_rand()} : '0;
            @(negedge core_clk);
            if (instr_rvalid !== 1'b0) report_mismatch("instr_rvalid_o", 1'b0, instr_rvalid);
            if (data_rvalid !== 1'b0) report_mismatch("data_rvalid_o", 1'b0, data_rvalid);
        end
        readback_all();
        finish_test("ownership", errs);

        // back-to-back fetches, rvalid one edge after each req
        errs = err_count;
        set_owner(1'b1);
        last_req = 1'b0;
        last_word = '0;
        for (int i = 0; i <= 24; i++) begin
            @(posedge core_clk);
            cur_req = (i < 24) && (next_rand() % 4 != 0);
            a = pick_addr(1'b0);
            instr_req <= {cur_req, to_byte_addr(a)};
            @(negedge core_clk);
            if (instr_rvalid !== last_req)
                report_mismatch("instr_rvalid_o", last_req, instr_rvalid);
            if (last_req && instr_rdata !== instr_model[last_word])
                report_mismatch("instr_rdata_o", instr_model[last_word], instr_rdata);
            last_req = cur_req;
            last_word = a;
        end
        finish_test("core fetch", errs);

        // byte writes, then core and host readback
        errs = err_count;
        for (int i = 0; i < 12; i++) begin
            core_data_access(1'b1, to_byte_addr(pick_addr(1'b1)), next_rand(), next_rand());
            core_data_access(1'b0, to_byte_addr(pick_addr(1'b1)), 4'h0, '0);
        end
        set_owner(1'b0);
        readback_all();
        finish_test("core byte writes", errs);

        // mailbox from core, then from host, then reset
        errs = err_count;
        set_owner(1'b1);
        for (int i = 0; i < 4; i++) begin
            old_flags = {model_debug, model_ready};
            wd = next_rand();
            core_data_access(1'b1, 32'h0000_1FFC | {30'h0, wd[1:0]},
                             next_rand(), next_rand());
            // flags unchanged on the ram write edge itself
            check_flags(old_flags[0], old_flags[1]);
            @(negedge core_clk);
            check_flags(model_ready, model_debug);
        end
        set_owner(1'b0);
        for (int i = 0; i < 4; i++) begin
            old_flags = {model_debug, model_ready};
            wd = next_rand();
            // last write leaves both flags set ahead of the reset
            if (i == 3) wd[1:0] = 2'b11;
            stream_access(1'b1, 1'b1, `RARE_STOP_ADDR, wd);
            check_flags(old_flags[0], old_flags[1]);
            @(negedge core_clk);
            check_flags(model_ready, model_debug);
        end
        @(posedge core_clk);
        core_resetb <= 1'b0;
        {model_debug, model_ready} = 2'b00;
        @(negedge core_clk);
        check_flags(model_ready, model_debug);
        @(posedge core_clk);
        core_resetb <= 1'b1;
        finish_test("mailbox flags", errs);

        // trace held at zero in reset, then one edge of delay
        errs = err_count;
        // nonzero outputs just before reset so the clear shows
        @(posedge core_clk);
        {if_in, id_in, ex_in} <= rand_trace();
        @(posedge core_clk);
        core_resetb <= 1'b0;
        for (int i = 0; i < 3; i++) begin
            new_tr = rand_trace();
            {if_in, id_in, ex_in} <= new_tr;
            @(negedge core_clk);
            if ({if_out, id_out, ex_out} !== '0) begin
                $display("trace outputs not cleared during reset");
                err_count++;
            end
            @(posedge core_clk);
        end
        core_resetb <= 1'b1;
        trace_q.push_back(new_tr);
        for (int i = 0; i < 16; i++) begin
            @(posedge core_clk);
            new_tr = rand_trace();
            {if_in, id_in, ex_in} <= new_tr;
            @(negedge core_clk);
            exp_tr = trace_q.pop_front();
            if (if_out !== exp_tr.if_tr) report_mismatch("if_trace_o", exp_tr.if_tr, if_out);
            if (id_out !== exp_tr.id_tr) report_mismatch("id_trace_o", exp_tr.id_tr, id_out);
            if (ex_out !== exp_tr.ex_tr) report_mismatch("ex_trace_o", exp_tr.ex_tr, ex_out);
            trace_q.push_back(new_tr);
        end
        finish_test("trace capture", errs);

        $display("%0d tests run, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+logic
logic/rare_mem_pkg.sv
logic/rare_trace_pkg.sv
logic/sram_model.sv
logic/mem_bank.sv
logic/stop_ctrl.sv
logic/trace_capture.sv
logic/rare_mem_top.sv
verif/rare_mem_tb.sv
